// ==== compile.f ====
common/perf_mon_pkg.sv
common/status_map_pkg.sv
common/perf_snapshot_if.sv
monitor/tap_sync.sv
monitor/perf_counters.sv
source/status_regs.sv
source/perf_mon_top.sv
sim/perf_mon_checker.sv
sim/tb_perf_mon.sv

// ==== sim/tb_perf_mon.sv ====
// Testbench for the performance monitor
// Bus tasks, stream stimulus, value checks and watchdog
`timescale 1ns/1ps

module tb_perf_mon import status_map_pkg::*; ();

   localparam int          CLK_PERIOD = 100;   // ns
   localparam int          RST_CYCLES = 10;
   localparam logic [15:0] BASE       = 16'h1000;   // Prefix 000100, then four zeros
   localparam logic [31:0] ID_WORD    = "CLNT";
   localparam int          N_TX       = 12;
   localparam int          M_RX       = 14;
   localparam int          N_STALL    = 4;
   localparam int          MAX_LEN    = 8;
   localparam int          N_BUS_OPS  = 80;
   // Worst beat is idle plus held plus accepted
   localparam int          TRAFFIC    = (N_TX + M_RX + 2 * N_STALL) * (MAX_LEN * 3 + 1);
   localparam int          WD_CYCLES  = RST_CYCLES + TRAFFIC + N_BUS_OPS * 2 + 500;

   logic        clk_status = 1'b0;
   logic        perf_count_rst;
   logic        tx_sop, tx_eop, tx_valid, tx_ready;
   logic        rx_sop, rx_eop, rx_valid;
   logic [5:0]  rx_error;
   logic        status_read, status_write;
   logic [15:0] status_addr;
   logic [31:0] status_writedata;
   logic [31:0] status_readdata;
   logic        status_readdata_valid;

   logic [31:0] lfsr = 32'hf7d2_6820;
   int          cyc = 0;
   int          n_checks = 0;
   int          n_errs = 0;
   longint      exp_tx = 0, exp_rx = 0, exp_good = 0;
   logic        tx_seen = 1'b0, rx_seen = 1'b0;
   int          tx_first, tx_last, rx_first, rx_last;

   perf_mon_top dut0 (
      .i_clk_status (clk_status), .perf_count_rst (perf_count_rst),
      .i_tx_sop (tx_sop), .i_tx_eop (tx_eop), .i_tx_valid (tx_valid), .i_tx_ready (tx_ready),
      .i_rx_sop (rx_sop), .i_rx_eop (rx_eop), .i_rx_valid (rx_valid), .i_rx_error (rx_error),
      .i_status_read (status_read), .i_status_write (status_write),
      .i_status_addr (status_addr), .i_status_writedata (status_writedata),
      .o_status_readdata (status_readdata), .o_status_readdata_valid (status_readdata_valid)
   );

   always #(CLK_PERIOD / 2) clk_status = ~clk_status;
   always @(posedge clk_status) cyc <= cyc + 1;

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
      n_checks++;
      assert (act === exp) else begin
         $display("ERR %s expected %0h actual %0h", name, exp, act);
         n_errs++;
      end
   endtask

   task automatic tick();
      @(posedge clk_status);
      #1;
   endtask

   task automatic bus_write(input logic [5:0] ofs, input logic [31:0] data);
      status_addr      = BASE | 16'(ofs);
      status_writedata = data;
      status_write     = 1'b1;
      tick();
      status_write = 1'b0;
      tick();   // Write lands here
   endtask

   task automatic bus_read(input logic [15:0] addr, output logic [31:0] data, output logic vld);
      status_addr = addr;
      status_read = 1'b1;
      tick();
      status_read = 1'b0;
      tick();
      data = status_readdata;
      vld  = status_readdata_valid;
   endtask

   task automatic read_word(input logic [5:0] ofs, output logic [31:0] data);
      logic vld;
      bus_read(BASE | 16'(ofs), data, vld);
      check_eq("read valid", 64'd1, 64'(vld));
   endtask

   task automatic expect_pair(input string name, input logic [5:0] lo, input logic [63:0] exp);
      logic [31:0] w_lo;
      logic [31:0] w_hi;
      read_word(lo, w_lo);
      read_word(lo + 6'd1, w_hi);
      check_eq(name, exp, {w_hi, w_lo});
   endtask

   task automatic tx_drive(input logic sop, input logic eop, input logic vld, input logic rdy);
      tx_sop   = sop;
      tx_eop   = eop;
      tx_valid = vld;
      tx_ready = rdy;
      if (sop && vld && rdy && !tx_seen) begin
         tx_first = cyc;
         tx_seen  = 1'b1;
      end
      if (eop && vld && rdy) tx_last = cyc;
      tick();
   endtask

   task automatic rx_drive(input logic sop, input logic eop, input logic vld, input logic [5:0] e);
      rx_sop   = sop;
      rx_eop   = eop;
      rx_valid = vld;
      rx_error = e;
      if (sop && vld && !rx_seen) begin
         rx_first = cyc;
         rx_seen  = 1'b1;
      end
      if (eop && vld) rx_last = cyc;
      tick();
   endtask

   task automatic send_tx_packet();
      logic [31:0] r;
      int          len;
      take_bits(3, r);
      len = int'(r) + 1;
      for (int b = 0; b < len; b++) begin
         take_bits(2, r);
         if (r == 0) tx_drive(b == 0, b == len - 1, 1'b0, 1'b1);   // Idle beat
         take_bits(2, r);
         if (r == 0) tx_drive(b == 0, b == len - 1, 1'b1, 1'b0);   // Ready low, ignored
         tx_drive(b == 0, b == len - 1, 1'b1, 1'b1);
      end
      tx_drive(1'b0, 1'b0, 1'b0, 1'b0);
      exp_tx++;
   endtask

   task automatic send_rx_packet();
      logic [31:0] r;
      logic [5:0]  err;
      int          len;
      take_bits(3, r);
      len = int'(r) + 1;
      take_bits(2, r);
      err = '0;
      if (r == 0 || exp_rx == 0) begin   // First packet always errored
         take_bits(6, r);
         err = r[5:0] | 6'h01;
      end
      for (int b = 0; b < len; b++) begin
         take_bits(2, r);
         if (r == 0) rx_drive(b == 0, b == len - 1, 1'b0, 6'h0);
         rx_drive(b == 0, b == len - 1, 1'b1, (b == len - 1) ? err : 6'h0);
      end
      rx_drive(1'b0, 1'b0, 1'b0, 6'h0);
      exp_rx++;
      if (err == 0) exp_good++;
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      logic [31:0] w;
      logic [31:0] r;
      logic        vld;
      longint      held_tx, held_rx, held_good;
      logic [31:0] st_lo, st_hi, en_lo, en_hi;
      perf_count_rst = 1'b1;
      {tx_sop, tx_eop, tx_valid, tx_ready} = '0;
      {rx_sop, rx_eop, rx_valid} = '0;
      rx_error         = '0;
      status_read      = 1'b0;
      status_write     = 1'b0;
      status_addr      = '0;
      status_writedata = '0;
      repeat (RST_CYCLES) @(posedge clk_status);
      #1;
      perf_count_rst = 1'b0;
      check_eq("reset readdata", 64'h0, 64'(status_readdata));
      check_eq("reset valid", 64'h0, 64'(status_readdata_valid));

      read_word(SCRATCH, w);
      check_eq("scratch reset", 64'h0, 64'(w));
      read_word(CTRL, w);
      check_eq("ctrl reset", 64'h0, 64'(w));
      read_word(ID, w);
      check_eq("id word", 64'(ID_WORD), 64'(w));
      read_word(FEATURES, w);
      check_eq("features", 64'h0, 64'(w));
      read_word(6'h05, w);
      check_eq("unmapped", 64'h123, 64'(w));
      bus_read(16'h2005, w, vld);
      check_eq("foreign valid", 64'h0, 64'(vld));
      check_eq("foreign data", 64'h0BAD_F00D, 64'(w));

      for (int i = 0; i < 8; i++) begin
         take_bits(32, r);
         bus_write(SCRATCH, r);
         read_word(SCRATCH, w);
         check_eq("scratch rw", 64'(r), 64'(w));
      end

      repeat (N_TX) send_tx_packet();
      repeat (M_RX) send_rx_packet();
      tick();
      repeat (6) tick();   // Let counts reach the snapshot
      expect_pair("tx count", TX_CNT_LO, exp_tx);
      expect_pair("rx count", RX_CNT_LO, exp_rx);
      expect_pair("rx good", RX_GOOD_LO, exp_good);

      // Stall holds the snapshot over new traffic
      held_tx   = exp_tx;
      held_rx   = exp_rx;
      held_good = exp_good;
      bus_write(CTRL, 32'h2);
      repeat (N_STALL) begin
         send_tx_packet();
         send_rx_packet();
      end
      repeat (6) tick();
      expect_pair("stall tx count", TX_CNT_LO, held_tx);
      expect_pair("stall rx count", RX_CNT_LO, held_rx);
      expect_pair("stall rx good", RX_GOOD_LO, held_good);
      bus_write(CTRL, 32'h0);
      repeat (2) tick();
      expect_pair("resume tx count", TX_CNT_LO, exp_tx);
      expect_pair("resume rx count", RX_CNT_LO, exp_rx);
      expect_pair("resume rx good", RX_GOOD_LO, exp_good);

      read_word(TX_START_LO, st_lo);
      read_word(TX_START_HI, st_hi);
      read_word(TX_END_LO, en_lo);
      read_word(TX_END_HI, en_hi);
      check_eq("tx span", 64'(tx_last - tx_first), {en_hi, en_lo} - {st_hi, st_lo});
      read_word(RX_START_LO, st_lo);
      read_word(RX_START_HI, st_hi);
      read_word(RX_END_LO, en_lo);
      read_word(RX_END_HI, en_hi);
      check_eq("rx span", 64'(rx_last - rx_first), {en_hi, en_lo} - {st_hi, st_lo});

      // Start stamps track time once released, so they are read while held
      bus_write(CTRL, 32'h1);
      expect_pair("held tx count", TX_CNT_LO, 64'h0);
      expect_pair("held tx start", TX_START_LO, 64'h0);
      expect_pair("held rx start", RX_START_LO, 64'h0);
      bus_write(CTRL, 32'h0);
      expect_pair("clear tx count", TX_CNT_LO, 64'h0);
      expect_pair("clear rx count", RX_CNT_LO, 64'h0);
      expect_pair("clear rx good", RX_GOOD_LO, 64'h0);
      expect_pair("clear tx end", TX_END_LO, 64'h0);
      expect_pair("clear rx end", RX_END_LO, 64'h0);

      repeat (4) tick();
      $display("Checks: %0d, value errors: %0d, assertion errors: %0d",
               n_checks, n_errs, dut0.u_chk.fail_cnt);
      if (n_errs == 0 && dut0.u_chk.fail_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(longint'(CLK_PERIOD) * WD_CYCLES);
      $display("Watchdog expired before the test sequence finished");
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== sim/perf_mon_checker.sv ====
// Bound assertions on status bus timing, tap latency and counter growth
`timescale 1ns/1ps

module perf_mon_checker import perf_mon_pkg::*, status_map_pkg::*; (
   input logic        i_clk_status,
   input logic        perf_count_rst,
   input logic        i_status_read,
   input logic [15:0] i_status_addr,
   input logic        i_readdata_valid,
   input logic        i_tx_sop,
   input logic        i_tx_valid,
   input logic        i_tx_ready,
   input logic        i_tx_sop_fire,
   input logic        i_clr,
   input cnt_t        i_tx_cnt,
   input cnt_t        i_rx_cnt,
   input cnt_t        i_rx_good_cnt
);

   int unsigned fail_cnt = 0;
   logic        hit;

   assign hit = i_status_read && (i_status_addr[15:6] == {STATUS_ADDR_PREFIX, 4'b0});

   a_valid_after_read : assert property (@(posedge i_clk_status) disable iff (perf_count_rst)
      hit |-> ##2 i_readdata_valid)
      else begin
         fail_cnt++;
         $error("readdata_valid missing two clocks after a matching read");
      end

   a_valid_only_for_read : assert property (@(posedge i_clk_status) disable iff (perf_count_rst)
      i_readdata_valid |-> $past(hit, 2))
      else begin
         fail_cnt++;
         $error("readdata_valid without a matching read two clocks earlier");
      end

   // Accepted TX sop shows up as a fire pulse after the registering stages
   a_tap_latency : assert property (@(posedge i_clk_status) disable iff (perf_count_rst)
      (i_tx_sop && i_tx_valid && i_tx_ready) |-> ##SYNC_STAGES i_tx_sop_fire)
      else begin
         fail_cnt++;
         $error("TX sop fire pulse late or missing");
      end

   a_counts_grow : assert property (@(posedge i_clk_status) disable iff (perf_count_rst)
      !i_clr |=> (i_tx_cnt >= $past(i_tx_cnt)) && (i_rx_cnt >= $past(i_rx_cnt))
                 && (i_rx_good_cnt >= $past(i_rx_good_cnt)))
      else begin
         fail_cnt++;
         $error("Packet counter decreased without a clear");
      end

endmodule

bind perf_mon_top perf_mon_checker u_chk (
   .i_clk_status     (i_clk_status),
   .perf_count_rst   (perf_count_rst),
   .i_status_read    (i_status_read),
   .i_status_addr    (i_status_addr),
   .i_readdata_valid (o_status_readdata_valid),
   .i_tx_sop         (i_tx_sop),
   .i_tx_valid       (i_tx_valid),
   .i_tx_ready       (i_tx_ready),
   .i_tx_sop_fire    (tx_sop_fire),
   .i_clr            (u_perf.clr),
   .i_tx_cnt         (u_perf.tx_cnt),
   .i_rx_cnt         (u_perf.rx_cnt),
   .i_rx_good_cnt    (u_perf.rx_good_cnt)
);

// ==== source/perf_mon_top.sv ====
// Performance monitor top, tap registering, counters and status registers
`timescale 1ns/1ps

module perf_mon_top import perf_mon_pkg::*; (
   input  logic             i_clk_status,
   input  logic             perf_count_rst,
   input  logic             i_tx_sop,
   input  logic             i_tx_eop,
   input  logic             i_tx_valid,
   input  logic             i_tx_ready,
   input  logic             i_rx_sop,
   input  logic             i_rx_eop,
   input  logic             i_rx_valid,
   input  logic [ERR_W-1:0] i_rx_error,
   input  logic             i_status_read,
   input  logic             i_status_write,
   input  logic [15:0]      i_status_addr,
   input  logic [31:0]      i_status_writedata,
   output logic [31:0]      o_status_readdata,
   output logic             o_status_readdata_valid
);

   tap_t tap;
   logic tx_sop_fire;
   logic tx_eop_fire;
   logic rx_sop_fire;
   logic rx_eop_fire;
   logic log_clear;
   logic stall;

   perf_snapshot_if snap_if ();

   tap_sync u_tap (
      .i_clk_status   (i_clk_status),
      .perf_count_rst (perf_count_rst),
      .i_tx_sop       (i_tx_sop),
      .i_tx_eop       (i_tx_eop),
      .i_tx_valid     (i_tx_valid),
      .i_tx_ready     (i_tx_ready),
      .i_rx_sop       (i_rx_sop),
      .i_rx_eop       (i_rx_eop),
      .i_rx_valid     (i_rx_valid),
      .i_rx_error     (i_rx_error),
      .o_tap          (tap),
      .o_tx_sop_fire  (tx_sop_fire),
      .o_tx_eop_fire  (tx_eop_fire),
      .o_rx_sop_fire  (rx_sop_fire),
      .o_rx_eop_fire  (rx_eop_fire)
   );

   perf_counters u_perf (
      .i_clk_status   (i_clk_status),
      .perf_count_rst (perf_count_rst),
      .i_log_clear    (log_clear),
      .i_stall        (stall),
      .i_tap          (tap),
      .i_tx_sop_fire  (tx_sop_fire),
      .i_tx_eop_fire  (tx_eop_fire),
      .i_rx_sop_fire  (rx_sop_fire),
      .i_rx_eop_fire  (rx_eop_fire),
      .snap           (snap_if.producer)
   );

   status_regs u_regs (
      .i_clk_status            (i_clk_status),
      .perf_count_rst          (perf_count_rst),
      .i_status_addr           (i_status_addr),
      .i_status_read           (i_status_read),
      .i_status_write          (i_status_write),
      .i_status_writedata      (i_status_writedata),
      .snap                    (snap_if.consumer),
      .o_log_clear             (log_clear),
      .o_stall                 (stall),
      .o_status_readdata       (o_status_readdata),
      .o_status_readdata_valid (o_status_readdata_valid)
   );

endmodule

// ==== source/status_regs.sv ====
// Status bus decode, scratch and control registers
// Two-stage read path over the counter snapshot
`timescale 1ns/1ps

module status_regs import status_map_pkg::*; (
   input  logic        i_clk_status,
   input  logic        perf_count_rst,
   input  logic [15:0] i_status_addr,
   input  logic        i_status_read,
   input  logic        i_status_write,
   input  logic [31:0] i_status_writedata,
   perf_snapshot_if.consumer snap,
   output logic        o_log_clear,
   output logic        o_stall,
   output logic [31:0] o_status_readdata,
   output logic        o_status_readdata_valid
);

   reg_ofs_e    addr_r;
   logic        sel_r;
   logic        read_r;
   logic        write_r;
   logic [31:0] wdata_r;
   logic [31:0] scratch;
   logic        stall;
   logic        reset_log;
   logic [31:0] rd_word;

   ////////////////////////////////////////
   // Request stage
   ////////////////////////////////////////

   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst) begin
         sel_r   <= 1'b0;
         read_r  <= 1'b0;
         write_r <= 1'b0;
      end else begin
         sel_r   <= (i_status_addr[15:6] == {STATUS_ADDR_PREFIX, 4'b0});
         read_r  <= i_status_read;
         write_r <= i_status_write;
      end
   end

   always_ff @(posedge i_clk_status) begin
      addr_r  <= reg_ofs_e'(i_status_addr[5:0]);
      wdata_r <= i_status_writedata;
   end

   // Read word select
   always_comb begin
      case (addr_r)
         SCRATCH     : rd_word = scratch;
         ID          : rd_word = CLIENT_ID;
         FEATURES    : rd_word = FEATURES_WORD;
         CTRL        : rd_word = {30'b0, stall, reset_log};
         TX_CNT_LO   : rd_word = snap.tx_cnt[31:0];
         TX_CNT_HI   : rd_word = snap.tx_cnt[63:32];
         RX_CNT_LO   : rd_word = snap.rx_cnt[31:0];
         RX_CNT_HI   : rd_word = snap.rx_cnt[63:32];
         RX_GOOD_LO  : rd_word = snap.rx_good_cnt[31:0];
         RX_GOOD_HI  : rd_word = snap.rx_good_cnt[63:32];
         TX_START_LO : rd_word = snap.tx_start[31:0];
         TX_START_HI : rd_word = snap.tx_start[63:32];
         TX_END_LO   : rd_word = snap.tx_end[31:0];
         TX_END_HI   : rd_word = snap.tx_end[63:32];
         RX_START_LO : rd_word = snap.rx_start[31:0];
         RX_START_HI : rd_word = snap.rx_start[63:32];
         RX_END_LO   : rd_word = snap.rx_end[31:0];
         RX_END_HI   : rd_word = snap.rx_end[63:32];
         default     : rd_word = UNMAPPED_RDATA;
      endcase
   end

   ////////////////////////////////////////
   // Response and write stage
   ////////////////////////////////////////

   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst) begin
         o_status_readdata       <= '0;
         o_status_readdata_valid <= 1'b0;
      end else begin
         o_status_readdata_valid <= read_r & sel_r;
         if (read_r) begin
            o_status_readdata <= sel_r ? rd_word : FOREIGN_RDATA;   // Foreign read, no valid
         end
      end
   end

   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst) begin
         scratch   <= '0;
         stall     <= 1'b0;
         reset_log <= 1'b0;
      end else if (write_r && sel_r) begin
         case (addr_r)
            SCRATCH : scratch <= wdata_r;
            CTRL    : {stall, reset_log} <= wdata_r[1:0];
            default : ;
         endcase
      end
   end

   assign o_stall     = stall;
   assign o_log_clear = reset_log;   // Level, holds counters clear while set

endmodule

// ==== monitor/perf_counters.sv ====
// Free-running timestamp, packet counters, first/last stamps
// Snapshot registers frozen while stall is set
`timescale 1ns/1ps

module perf_counters import perf_mon_pkg::*; (
   input  logic             i_clk_status,
   input  logic             perf_count_rst,
   input  logic             i_log_clear,
   input  logic             i_stall,
   input  tap_t             i_tap,
   input  logic             i_tx_sop_fire,
   input  logic             i_tx_eop_fire,
   input  logic             i_rx_sop_fire,
   input  logic             i_rx_eop_fire,
   perf_snapshot_if.producer snap
);

   localparam int DIR_TX = 0;
   localparam int DIR_RX = 1;

   logic       clr;
   stamp_t     ts_cnt;
   cnt_t       tx_cnt;
   cnt_t       rx_cnt;
   cnt_t       rx_good_cnt;
   logic [1:0] sop_fire;
   logic [1:0] eop_fire;
   logic [1:0] logged;   // First sop seen, per direction
   stamp_t     start_q [2];
   stamp_t     end_q [2];

   assign clr = perf_count_rst | i_log_clear;

   assign sop_fire = {i_rx_sop_fire, i_tx_sop_fire};
   assign eop_fire = {i_rx_eop_fire, i_tx_eop_fire};

   ////////////////////////////////////////
   // Timestamp and packet counts
   ////////////////////////////////////////

   always_ff @(posedge i_clk_status) begin
      if (clr) begin
         ts_cnt <= '0;
      end else begin
         ts_cnt <= ts_cnt + 1'b1;
      end
   end

   always_ff @(posedge i_clk_status) begin
      if (clr) begin
         tx_cnt      <= '0;
         rx_cnt      <= '0;
         rx_good_cnt <= '0;
      end else begin
         if (i_tx_eop_fire) tx_cnt <= tx_cnt + 1'b1;
         if (i_rx_eop_fire) begin
            rx_cnt <= rx_cnt + 1'b1;
            if (!i_tap.rx_err_any) rx_good_cnt <= rx_good_cnt + 1'b1;   // Clean at eop
         end
      end
   end

   ////////////////////////////////////////
   // First sop and last eop stamps
   ////////////////////////////////////////

   always_ff @(posedge i_clk_status) begin
      if (clr) begin
         logged <= '0;
         for (int d = 0; d < 2; d++) begin
            start_q[d] <= '0;
            end_q[d]   <= '0;
         end
      end else begin
         for (int d = 0; d < 2; d++) begin
            if (sop_fire[d]) logged[d] <= 1'b1;
            if (!logged[d]) start_q[d] <= ts_cnt;   // Tracks until first sop
            if (eop_fire[d]) end_q[d] <= ts_cnt;
         end
      end
   end

   // Readable copy, held under stall
   always_ff @(posedge i_clk_status) begin
      if (clr) begin
         snap.tx_cnt      <= '0;
         snap.rx_cnt      <= '0;
         snap.rx_good_cnt <= '0;
         snap.tx_start    <= '0;
         snap.tx_end      <= '0;
         snap.rx_start    <= '0;
         snap.rx_end      <= '0;
      end else if (!i_stall) begin
         snap.tx_cnt      <= tx_cnt;
         snap.rx_cnt      <= rx_cnt;
         snap.rx_good_cnt <= rx_good_cnt;
         snap.tx_start    <= start_q[DIR_TX];
         snap.tx_end      <= end_q[DIR_TX];
         snap.rx_start    <= start_q[DIR_RX];
         snap.rx_end      <= end_q[DIR_RX];
      end
   end

endmodule

// ==== monitor/tap_sync.sv ====
// Registering stages for the TX and RX stream taps
// Qualified sop and eop event pulses
`timescale 1ns/1ps

module tap_sync import perf_mon_pkg::*; (
   input  logic             i_clk_status,
   input  logic             perf_count_rst,
   input  logic             i_tx_sop,
   input  logic             i_tx_eop,
   input  logic             i_tx_valid,
   input  logic             i_tx_ready,
   input  logic             i_rx_sop,
   input  logic             i_rx_eop,
   input  logic             i_rx_valid,
   input  logic [ERR_W-1:0] i_rx_error,
   output tap_t             o_tap,
   output logic             o_tx_sop_fire,
   output logic             o_tx_eop_fire,
   output logic             o_rx_sop_fire,
   output logic             o_rx_eop_fire
);

   tap_t tap_in;
   tap_t stage [SYNC_STAGES];
   tap_t tap_q;

   always_comb begin
      tap_in.tx_sop     = i_tx_sop;
      tap_in.tx_eop     = i_tx_eop;
      tap_in.tx_valid   = i_tx_valid;
      tap_in.tx_ready   = i_tx_ready;
      tap_in.rx_sop     = i_rx_sop;
      tap_in.rx_eop     = i_rx_eop;
      tap_in.rx_valid   = i_rx_valid;
      tap_in.rx_err_any = |i_rx_error;   // Only error presence matters
   end

   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst) begin
         for (int i = 0; i < SYNC_STAGES; i++) begin
            stage[i] <= '0;
         end
      end else begin
         stage[0] <= tap_in;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            stage[i] <= stage[i-1];
         end
      end
   end

   assign tap_q = stage[SYNC_STAGES-1];
   assign o_tap = tap_q;

   // TX beat needs ready, RX has none
   assign o_tx_sop_fire = tap_q.tx_sop & tap_q.tx_valid & tap_q.tx_ready;
   assign o_tx_eop_fire = tap_q.tx_eop & tap_q.tx_valid & tap_q.tx_ready;
   assign o_rx_sop_fire = tap_q.rx_sop & tap_q.rx_valid;
   assign o_rx_eop_fire = tap_q.rx_eop & tap_q.rx_valid;

endmodule

// ==== common/perf_snapshot_if.sv ====
// Held counter and timestamp snapshot, producer and consumer views
`timescale 1ns/1ps

interface perf_snapshot_if import perf_mon_pkg::*; ();

   cnt_t   tx_cnt;
   cnt_t   rx_cnt;
   cnt_t   rx_good_cnt;
   stamp_t tx_start;
   stamp_t tx_end;
   stamp_t rx_start;
   stamp_t rx_end;

   modport producer (
      output tx_cnt, rx_cnt, rx_good_cnt,
      output tx_start, tx_end, rx_start, rx_end
   );

   modport consumer (
      input tx_cnt, rx_cnt, rx_good_cnt,
      input tx_start, tx_end, rx_start, rx_end
   );

endinterface

// ==== common/status_map_pkg.sv ====
// Status bus register offsets and fixed read words
package status_map_pkg;

   typedef enum logic [5:0] {
      SCRATCH     = 6'h00,
      ID          = 6'h01,
      FEATURES    = 6'h02,
      CTRL        = 6'h18,
      TX_CNT_LO   = 6'h19,
      TX_CNT_HI   = 6'h1A,
      RX_CNT_LO   = 6'h1B,
      RX_CNT_HI   = 6'h1C,
      RX_GOOD_LO  = 6'h1D,
      RX_GOOD_HI  = 6'h1E,
      TX_START_LO = 6'h1F,
      TX_START_HI = 6'h20,
      TX_END_LO   = 6'h21,
      TX_END_HI   = 6'h22,
      RX_START_LO = 6'h23,
      RX_START_HI = 6'h24,
      RX_END_LO   = 6'h25,
      RX_END_HI   = 6'h26
   } reg_ofs_e;

   // Block occupies 0x1000-0x103f
   localparam logic [5:0]  STATUS_ADDR_PREFIX = 6'b000100;

   localparam logic [31:0] CLIENT_ID      = "CLNT";
   localparam logic [31:0] FEATURES_WORD  = 32'h0;
   localparam logic [31:0] UNMAPPED_RDATA = 32'h123;
   localparam logic [31:0] FOREIGN_RDATA  = 32'h0BAD_F00D;

endpackage

// ==== common/perf_mon_pkg.sv ====
// Stream tap bundle, counter and timestamp types
// Synchronizer depth for the tap registering stages
package perf_mon_pkg;

   localparam int CNT_W       = 64;
   localparam int STAMP_W     = 64;
   localparam int ERR_W       = 6;   // RX error field
   localparam int SYNC_STAGES = 2;

   typedef logic [CNT_W-1:0]   cnt_t;
   typedef logic [STAMP_W-1:0] stamp_t;

   // Registered copy of both stream taps
   typedef struct packed {
      logic tx_sop;
      logic tx_eop;
      logic tx_valid;
      logic tx_ready;
      logic rx_sop;
      logic rx_eop;
      logic rx_valid;
      logic rx_err_any;   // OR of the RX error field
   } tap_t;

endpackage
